// ==== hdl/sba_params.svh ====
`ifndef SBA_PARAMS_SVH
`define SBA_PARAMS_SVH

// system bus side
`define SBA_ADDR_W      32
`define SBA_BUS_DATA_W  64
`define SBA_STRB_W      8

// debug module interface
`define SBA_DMI_ADDR_W  7
`define SBA_DMI_DATA_W  32

`endif

// ==== hdl/dm_reg_pkg.sv ====
`include "sba_params.svh"

package dm_reg_pkg;

   // debug registers implemented by this block
   typedef enum logic [`SBA_DMI_ADDR_W-1:0] {
      DMCONTROL  = 7'h10,
      SBCS       = 7'h38,
      SBADDRESS0 = 7'h39,
      SBDATA0    = 7'h3c,
      SBDATA1    = 7'h3d
   } dmi_addr_e;

   // sberror codes
   typedef enum logic [2:0] {
      NONE      = 3'd0,
      BUS_ERR   = 3'd2,   // error response from the bus
      UNALIGNED = 3'd3,
      BAD_SIZE  = 3'd4
   } sb_err_e;

   localparam int DMACTIVE_BIT = 0;

   // sbcs field positions
   localparam int SBCS_BUSYERR_BIT  = 22;
   localparam int SBCS_BUSY_BIT     = 21;
   localparam int SBCS_RDONADDR_BIT = 20;
   localparam int SBCS_ACCESS_HI    = 19;
   localparam int SBCS_ACCESS_LO    = 17;
   localparam int SBCS_AUTOINC_BIT  = 16;
   localparam int SBCS_RDONDATA_BIT = 15;
   localparam int SBCS_ERR_HI       = 14;
   localparam int SBCS_ERR_LO       = 12;

   // read-only sbcs fields
   localparam logic [2:0] SBCS_CONST_VERSION = 3'd1;
   localparam logic [6:0] SBCS_ASIZE         = 7'd32;
   localparam logic [3:0] SBCS_ACCESS        = 4'b1111;   // 64/32/16/8 supported

endpackage

// ==== hdl/sb_bus_pkg.sv ====
package sb_bus_pkg;

   // access size, log2 of the byte count
   typedef logic [2:0] sb_size_t;

   localparam sb_size_t SIZE_64 = 3'd3;   // largest legal size

   typedef enum logic [3:0] {
      SB_IDLE     = 4'h0,
      WAIT_RD     = 4'h1,
      WAIT_WR     = 4'h2,
      CMD_RD      = 4'h3,
      CMD_WR      = 4'h4,
      CMD_WR_ADDR = 4'h5,   // data beat taken, address pending
      CMD_WR_DATA = 4'h6,   // address taken, data pending
      RSP_RD      = 4'h7,
      RSP_WR      = 4'h8,
      SB_DONE     = 4'h9
   } sb_state_e;

   // bus response code
   typedef logic [1:0] bus_resp_t;

   localparam bus_resp_t RESP_OKAY = 2'b00;

endpackage

// ==== hdl/sba_dmi_regs.sv ====
`timescale 1ns/100ps
`include "sba_params.svh"

module sba_dmi_regs (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         dmi_en,
   input  logic                         dmi_wr,
   input  logic [`SBA_DMI_ADDR_W-1:0]   dmi_addr,
   input  logic [`SBA_DMI_DATA_W-1:0]   dmi_wdata,
   output logic [`SBA_DMI_DATA_W-1:0]   dmi_rdata,
   input  logic                         busy,
   input  logic                         rd_capture,
   input  logic                         err_set,
   input  dm_reg_pkg::sb_err_e          err_code,
   input  logic                         incr,
   input  logic [`SBA_BUS_DATA_W-1:0]   rd_aligned,
   output logic                         start_rd,
   output logic                         start_wr,
   output logic [`SBA_ADDR_W-1:0]       sb_addr,
   output sb_bus_pkg::sb_size_t         sb_size,
   output logic [`SBA_DMI_DATA_W-1:0]   sb_data0,
   output logic [`SBA_DMI_DATA_W-1:0]   sb_data1,
   output logic                         dm_active
);

   logic                        wr_dmcontrol, wr_sbcs;
   logic                        wr_addr0, wr_data0, wr_data1;
   logic                        rd_data0, sb_access, start_ok;
   logic                        busy_err, rd_on_addr, auto_incr, rd_on_data;
   logic [2:0]                  sb_err;
   logic [`SBA_DMI_DATA_W-1:0]  sbcs_val, rdata_nxt;

   // ************************************************************
   // DMI decode
   // ************************************************************
   assign wr_dmcontrol = dmi_en & dmi_wr & (dmi_addr == dm_reg_pkg::DMCONTROL);
   assign wr_sbcs      = dmi_en & dmi_wr & (dmi_addr == dm_reg_pkg::SBCS);
   assign wr_addr0     = dmi_en & dmi_wr & (dmi_addr == dm_reg_pkg::SBADDRESS0);
   assign wr_data0     = dmi_en & dmi_wr & (dmi_addr == dm_reg_pkg::SBDATA0);
   assign wr_data1     = dmi_en & dmi_wr & (dmi_addr == dm_reg_pkg::SBDATA1);
   assign rd_data0     = dmi_en & ~dmi_wr & (dmi_addr == dm_reg_pkg::SBDATA0);

   // any touch of the address or data regs counts against a busy bus
   assign sb_access = dmi_en & ((dmi_addr == dm_reg_pkg::SBADDRESS0) |
                                (dmi_addr == dm_reg_pkg::SBDATA0)    |
                                (dmi_addr == dm_reg_pkg::SBDATA1));

   assign start_ok = dm_active & ~busy;
   assign start_wr = start_ok & wr_data0;
   assign start_rd = start_ok & ((wr_addr0 & rd_on_addr) | (rd_data0 & rd_on_data));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         dm_active <= 1'b0;
      else if (wr_dmcontrol)
         dm_active <= dmi_wdata[dm_reg_pkg::DMACTIVE_BIT];
   end

   // ************************************************************
   // sbcs fields
   // ************************************************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy_err   <= 1'b0;
         rd_on_addr <= 1'b0;
         sb_size    <= '0;
         auto_incr  <= 1'b0;
         rd_on_data <= 1'b0;
         sb_err     <= '0;
      end else if (!dm_active) begin
         busy_err   <= 1'b0;
         rd_on_addr <= 1'b0;
         sb_size    <= '0;
         auto_incr  <= 1'b0;
         rd_on_data <= 1'b0;
         sb_err     <= '0;
      end else begin
         if (busy & sb_access)
            busy_err <= 1'b1;
         else if (wr_sbcs & dmi_wdata[dm_reg_pkg::SBCS_BUSYERR_BIT])
            busy_err <= 1'b0;   // w1c
         if (wr_sbcs & ~busy) begin   // config frozen during an access
            rd_on_addr <= dmi_wdata[dm_reg_pkg::SBCS_RDONADDR_BIT];
            sb_size    <= dmi_wdata[dm_reg_pkg::SBCS_ACCESS_HI:dm_reg_pkg::SBCS_ACCESS_LO];
            auto_incr  <= dmi_wdata[dm_reg_pkg::SBCS_AUTOINC_BIT];
            rd_on_data <= dmi_wdata[dm_reg_pkg::SBCS_RDONDATA_BIT];
         end
         if (err_set)
            sb_err <= err_code;
         else if (wr_sbcs)
            sb_err <= sb_err & ~dmi_wdata[dm_reg_pkg::SBCS_ERR_HI:dm_reg_pkg::SBCS_ERR_LO];
      end
   end

   // address and data, cleared while dmactive is low
   always_ff @(posedge clk) begin
      if (!dm_active) begin
         sb_addr  <= '0;
         sb_data0 <= '0;
         sb_data1 <= '0;
      end else begin
         if (incr & auto_incr)
            sb_addr <= sb_addr + (`SBA_ADDR_W'(1) << sb_size);   // next naturally aligned slot
         else if (wr_addr0 & ~busy)
            sb_addr <= dmi_wdata;
         if (rd_capture) begin
            sb_data0 <= rd_aligned[31:0];
            sb_data1 <= rd_aligned[63:32];
         end else begin
            if (wr_data0 & ~busy)
               sb_data0 <= dmi_wdata;
            if (wr_data1 & ~busy)
               sb_data1 <= dmi_wdata;
         end
      end
   end

   // ************************************************************
   // read back
   // ************************************************************
   assign sbcs_val = {dm_reg_pkg::SBCS_CONST_VERSION, 6'b0, busy_err, busy, rd_on_addr,
                      sb_size, auto_incr, rd_on_data, sb_err,
                      dm_reg_pkg::SBCS_ASIZE, 1'b0, dm_reg_pkg::SBCS_ACCESS};

   always_comb begin
      rdata_nxt = '0;   // unmapped reads 0
      case (dmi_addr)
         dm_reg_pkg::DMCONTROL:  rdata_nxt = {31'b0, dm_active};
         dm_reg_pkg::SBCS:       rdata_nxt = sbcs_val;
         dm_reg_pkg::SBADDRESS0: rdata_nxt = sb_addr;
         dm_reg_pkg::SBDATA0:    rdata_nxt = sb_data0;
         dm_reg_pkg::SBDATA1:    rdata_nxt = sb_data1;
         default:                rdata_nxt = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         dmi_rdata <= '0;
      else if (dmi_en)
         dmi_rdata <= rdata_nxt;   // held until the next strobe
   end

endmodule

// ==== hdl/sba_ctrl.sv ====
`timescale 1ns/100ps

module sba_ctrl (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   dm_active,
   input  logic                   start_rd,
   input  logic                   start_wr,
   input  logic [2:0]             sb_addr,   // low bits for the alignment check
   input  sb_bus_pkg::sb_size_t   sb_size,
   output logic                   busy,
   output logic                   aw_valid,
   output logic                   w_valid,
   output logic                   ar_valid,
   input  logic                   aw_ready,
   input  logic                   w_ready,
   input  logic                   ar_ready,
   input  logic                   b_valid,
   input  sb_bus_pkg::bus_resp_t  b_resp,
   input  logic                   r_valid,
   input  sb_bus_pkg::bus_resp_t  r_resp,
   output logic                   rd_capture,
   output logic                   err_set,
   output dm_reg_pkg::sb_err_e    err_code,
   output logic                   incr
);

   sb_bus_pkg::sb_state_e  state, state_nxt;
   logic                   bad_size, unaligned, chk_err;
   logic                   in_wait, rsp_err;
   logic [2:0]             align_mask;

   // ************************************************************
   // access checks
   // ************************************************************
   assign bad_size   = sb_size > sb_bus_pkg::SIZE_64;
   assign align_mask = (3'b001 << sb_size[1:0]) - 3'b001;
   assign unaligned  = |(sb_addr & align_mask);
   assign chk_err    = bad_size | unaligned;

   assign in_wait = (state == sb_bus_pkg::WAIT_RD) | (state == sb_bus_pkg::WAIT_WR);
   assign rsp_err = ((state == sb_bus_pkg::RSP_RD) & r_valid & (r_resp != sb_bus_pkg::RESP_OKAY)) |
                    ((state == sb_bus_pkg::RSP_WR) & b_valid & (b_resp != sb_bus_pkg::RESP_OKAY));

   always_comb begin
      state_nxt = state;
      case (state)
         sb_bus_pkg::SB_IDLE: begin
            if (start_wr)
               state_nxt = sb_bus_pkg::WAIT_WR;
            else if (start_rd)
               state_nxt = sb_bus_pkg::WAIT_RD;
         end
         sb_bus_pkg::WAIT_RD:
            state_nxt = chk_err ? sb_bus_pkg::SB_DONE : sb_bus_pkg::CMD_RD;
         sb_bus_pkg::WAIT_WR:
            state_nxt = chk_err ? sb_bus_pkg::SB_DONE : sb_bus_pkg::CMD_WR;
         sb_bus_pkg::CMD_RD:
            if (ar_ready) state_nxt = sb_bus_pkg::RSP_RD;
         sb_bus_pkg::CMD_WR: begin   // address and data may land in either order
            if (aw_ready & w_ready)
               state_nxt = sb_bus_pkg::RSP_WR;
            else if (aw_ready)
               state_nxt = sb_bus_pkg::CMD_WR_DATA;
            else if (w_ready)
               state_nxt = sb_bus_pkg::CMD_WR_ADDR;
         end
         sb_bus_pkg::CMD_WR_ADDR:
            if (aw_ready) state_nxt = sb_bus_pkg::RSP_WR;
         sb_bus_pkg::CMD_WR_DATA:
            if (w_ready) state_nxt = sb_bus_pkg::RSP_WR;
         sb_bus_pkg::RSP_RD:
            if (r_valid) state_nxt = sb_bus_pkg::SB_DONE;
         sb_bus_pkg::RSP_WR:
            if (b_valid) state_nxt = sb_bus_pkg::SB_DONE;
         default:
            state_nxt = sb_bus_pkg::SB_IDLE;   // SB_DONE and stray codes
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         state <= sb_bus_pkg::SB_IDLE;
      else if (!dm_active)
         state <= sb_bus_pkg::SB_IDLE;
      else
         state <= state_nxt;
   end

   // ************************************************************
   // outputs
   // ************************************************************
   assign busy     = state != sb_bus_pkg::SB_IDLE;
   assign ar_valid = state == sb_bus_pkg::CMD_RD;
   assign aw_valid = (state == sb_bus_pkg::CMD_WR) | (state == sb_bus_pkg::CMD_WR_ADDR);
   assign w_valid  = (state == sb_bus_pkg::CMD_WR) | (state == sb_bus_pkg::CMD_WR_DATA);

   assign rd_capture = (state == sb_bus_pkg::RSP_RD) & r_valid &
                       (r_resp == sb_bus_pkg::RESP_OKAY);
   assign err_set    = (in_wait & chk_err) | rsp_err;
   assign err_code   = !in_wait ? dm_reg_pkg::BUS_ERR   :
                       bad_size ? dm_reg_pkg::BAD_SIZE  : dm_reg_pkg::UNALIGNED;
   assign incr       = state == sb_bus_pkg::SB_DONE;   // qualified by autoincrement in the regs

endmodule

// ==== hdl/sba_lane_align.sv ====
`timescale 1ns/100ps
`include "sba_params.svh"

module sba_lane_align (
   input  logic [2:0]                   sb_addr,
   input  sb_bus_pkg::sb_size_t         sb_size,
   input  logic [`SBA_DMI_DATA_W-1:0]   sb_data0,
   input  logic [`SBA_DMI_DATA_W-1:0]   sb_data1,
   input  logic [`SBA_BUS_DATA_W-1:0]   r_data,
   output logic [`SBA_BUS_DATA_W-1:0]   w_data,
   output logic [`SBA_STRB_W-1:0]       w_strb,
   output logic [`SBA_BUS_DATA_W-1:0]   rd_aligned
);

   logic [2:0]                   lane_off;   // byte offset of the addressed lane
   logic [`SBA_STRB_W-1:0]       strb_base;
   logic [`SBA_BUS_DATA_W-1:0]   rd_shifted;

   always_comb begin
      case (sb_size)
         3'd0: begin
            lane_off  = sb_addr;
            strb_base = 8'h01;
            w_data    = {8{sb_data0[7:0]}};
         end
         3'd1: begin
            lane_off  = {sb_addr[2:1], 1'b0};
            strb_base = 8'h03;
            w_data    = {4{sb_data0[15:0]}};
         end
         3'd2: begin
            lane_off  = {sb_addr[2], 2'b00};
            strb_base = 8'h0f;
            w_data    = {2{sb_data0}};
         end
         default: begin   // full beat, sbdata1 on top
            lane_off  = 3'd0;
            strb_base = 8'hff;
            w_data    = {sb_data1, sb_data0};
         end
      endcase
   end

   assign w_strb     = strb_base << lane_off;
   assign rd_shifted = r_data >> {lane_off, 3'b000};

   // zero-fill above the access width
   always_comb begin
      case (sb_size)
         3'd0:    rd_aligned = {56'b0, rd_shifted[7:0]};
         3'd1:    rd_aligned = {48'b0, rd_shifted[15:0]};
         3'd2:    rd_aligned = {32'b0, rd_shifted[31:0]};
         default: rd_aligned = r_data;
      endcase
   end

endmodule

// ==== hdl/sba_top.sv ====
`timescale 1ns/100ps
`include "sba_params.svh"

module sba_top (
   input  logic                         clk,
   input  logic                         arst_n,
   // DMI
   input  logic                         dmi_en,
   input  logic                         dmi_wr,
   input  logic [`SBA_DMI_ADDR_W-1:0]   dmi_addr,
   input  logic [`SBA_DMI_DATA_W-1:0]   dmi_wdata,
   output logic [`SBA_DMI_DATA_W-1:0]   dmi_rdata,
   // write address / data / response
   output logic                         aw_valid,
   output logic [`SBA_ADDR_W-1:0]       aw_addr,
   output sb_bus_pkg::sb_size_t         aw_size,
   input  logic                         aw_ready,
   output logic                         w_valid,
   output logic [`SBA_BUS_DATA_W-1:0]   w_data,
   output logic [`SBA_STRB_W-1:0]       w_strb,
   input  logic                         w_ready,
   input  logic                         b_valid,
   input  sb_bus_pkg::bus_resp_t        b_resp,
   // read address / data
   output logic                         ar_valid,
   output logic [`SBA_ADDR_W-1:0]       ar_addr,
   output sb_bus_pkg::sb_size_t         ar_size,
   input  logic                         ar_ready,
   input  logic                         r_valid,
   input  logic [`SBA_BUS_DATA_W-1:0]   r_data,
   input  sb_bus_pkg::bus_resp_t        r_resp
);

   logic                         busy, start_rd, start_wr, dm_active;
   logic                         rd_capture, err_set, incr;
   dm_reg_pkg::sb_err_e          err_code;
   logic [`SBA_ADDR_W-1:0]       sb_addr;
   sb_bus_pkg::sb_size_t         sb_size;
   logic [`SBA_DMI_DATA_W-1:0]   sb_data0, sb_data1;
   logic [`SBA_BUS_DATA_W-1:0]   rd_aligned;

   // both address channels carry sbaddress0 and sbaccess
   assign aw_addr = sb_addr;
   assign ar_addr = sb_addr;
   assign aw_size = sb_size;
   assign ar_size = sb_size;

   sba_dmi_regs u_regs (
      .clk(clk), .arst_n(arst_n),
      .dmi_en(dmi_en), .dmi_wr(dmi_wr), .dmi_addr(dmi_addr),
      .dmi_wdata(dmi_wdata), .dmi_rdata(dmi_rdata),
      .busy(busy), .rd_capture(rd_capture), .err_set(err_set), .err_code(err_code),
      .incr(incr), .rd_aligned(rd_aligned),
      .start_rd(start_rd), .start_wr(start_wr), .sb_addr(sb_addr), .sb_size(sb_size),
      .sb_data0(sb_data0), .sb_data1(sb_data1), .dm_active(dm_active)
   );

   sba_ctrl u_ctrl (
      .clk(clk), .arst_n(arst_n), .dm_active(dm_active),
      .start_rd(start_rd), .start_wr(start_wr),
      .sb_addr(sb_addr[2:0]), .sb_size(sb_size), .busy(busy),
      .aw_valid(aw_valid), .w_valid(w_valid), .ar_valid(ar_valid),
      .aw_ready(aw_ready), .w_ready(w_ready), .ar_ready(ar_ready),
      .b_valid(b_valid), .b_resp(b_resp), .r_valid(r_valid), .r_resp(r_resp),
      .rd_capture(rd_capture), .err_set(err_set), .err_code(err_code), .incr(incr)
   );

   sba_lane_align u_align (
      .sb_addr(sb_addr[2:0]), .sb_size(sb_size),
      .sb_data0(sb_data0), .sb_data1(sb_data1), .r_data(r_data),
      .w_data(w_data), .w_strb(w_strb), .rd_aligned(rd_aligned)
   );

endmodule

// ==== dv/sba_mem_model.sv ====
`timescale 1ns/100ps
`include "sba_params.svh"

module sba_mem_model (
   input  logic                         clk,
   input  logic                         aw_valid,
   input  logic [`SBA_ADDR_W-1:0]       aw_addr,
   output logic                         aw_ready,
   input  logic                         w_valid,
   input  logic [`SBA_BUS_DATA_W-1:0]   w_data,
   input  logic [`SBA_STRB_W-1:0]       w_strb,
   output logic                         w_ready,
   output logic                         b_valid,
   output sb_bus_pkg::bus_resp_t        b_resp,
   input  logic                         ar_valid,
   input  logic [`SBA_ADDR_W-1:0]       ar_addr,
   output logic                         ar_ready,
   output logic                         r_valid,
   output logic [`SBA_BUS_DATA_W-1:0]   r_data,
   output sb_bus_pkg::bus_resp_t        r_resp
);

   logic [`SBA_BUS_DATA_W-1:0]  mem [0:255];   // 2 KB, aliased above that
   logic [`SBA_BUS_DATA_W-1:0]  wr_data, wr_mask;
   logic [`SBA_ADDR_W-1:0]      wr_addr, rd_addr;
   logic                        aw_got, w_got, wr_pend, rd_pend;
   logic                        aw_nxt, w_nxt, ar_nxt, b_nxt, r_nxt;
   int                          aw_wait, w_wait, ar_wait, b_wait, r_wait;

   initial begin
      int i;
      // each 32-bit lane holds its own byte address
      for (i = 0; i < 256; i++)
         mem[8'(i)] = {32'h5a00_0004 | 32'(i * 8), 32'h5a00_0000 | 32'(i * 8)};
      aw_ready = 1'b0;
      w_ready  = 1'b0;
      ar_ready = 1'b0;
      b_valid  = 1'b0;
      r_valid  = 1'b0;
      b_resp   = 2'd0;
      r_resp   = 2'd0;
      r_data   = '0;
      wr_addr  = '0;
      rd_addr  = '0;
      aw_got   = 1'b0;
      w_got    = 1'b0;
      wr_pend  = 1'b0;
      rd_pend  = 1'b0;
      aw_wait  = -1;
      w_wait   = -1;
      ar_wait  = -1;
      forever begin
         @(posedge clk);
         // ************************************************************
         // handshakes completed on this edge
         // ************************************************************
         if (aw_valid && aw_ready) begin
            aw_got  = 1'b1;
            wr_addr = aw_addr;
         end
         if (w_valid && w_ready) begin
            w_got   = 1'b1;
            wr_data = w_data;
            wr_mask = {{8{w_strb[7]}}, {8{w_strb[6]}}, {8{w_strb[5]}}, {8{w_strb[4]}},
                       {8{w_strb[3]}}, {8{w_strb[2]}}, {8{w_strb[1]}}, {8{w_strb[0]}}};
         end
         if (ar_valid && ar_ready) begin
            rd_pend = 1'b1;
            rd_addr = ar_addr;
            r_wait  = $urandom % 4;
         end
         if (aw_got && w_got) begin
            aw_got  = 1'b0;
            w_got   = 1'b0;
            wr_pend = 1'b1;
            b_wait  = $urandom % 4;
            if (!wr_addr[31])   // error region is never written
               mem[wr_addr[10:3]] = (mem[wr_addr[10:3]] & ~wr_mask) | (wr_data & wr_mask);
         end

         // ready after 0 to 3 idle cycles per channel
         aw_nxt = 1'b0;
         if (aw_valid && !aw_ready && !aw_got) begin
            if (aw_wait < 0)
               aw_wait = $urandom % 4;
            aw_nxt  = aw_wait == 0;
            aw_wait = aw_wait - 1;
         end
         w_nxt = 1'b0;
         if (w_valid && !w_ready && !w_got) begin
            if (w_wait < 0)
               w_wait = $urandom % 4;
            w_nxt  = w_wait == 0;
            w_wait = w_wait - 1;
         end
         ar_nxt = 1'b0;
         if (ar_valid && !ar_ready && !rd_pend) begin
            if (ar_wait < 0)
               ar_wait = $urandom % 4;
            ar_nxt  = ar_wait == 0;
            ar_wait = ar_wait - 1;
         end

         // single-cycle responses
         b_nxt = 1'b0;
         if (wr_pend) begin
            if (b_wait == 0) begin
               b_nxt   = 1'b1;
               wr_pend = 1'b0;
            end else
               b_wait = b_wait - 1;
         end
         r_nxt = 1'b0;
         if (rd_pend) begin
            if (r_wait == 0) begin
               r_nxt   = 1'b1;
               rd_pend = 1'b0;
            end else
               r_wait = r_wait - 1;
         end

         #10;
         aw_ready = aw_nxt;
         w_ready  = w_nxt;
         ar_ready = ar_nxt;
         b_valid  = b_nxt;
         b_resp   = wr_addr[31] ? 2'd2 : 2'd0;   // slave error at 0x8000_0000 and up
         r_valid  = r_nxt;
         r_resp   = rd_addr[31] ? 2'd2 : 2'd0;
         r_data   = (r_nxt && !rd_addr[31]) ? mem[rd_addr[10:3]] : '0;
      end
   end

endmodule

// ==== dv/sba_tb.sv ====
`timescale 1ns/100ps
`include "sba_params.svh"

module sba_tb;

   localparam logic [1:0] OP_WR   = 2'd0;
   localparam logic [1:0] OP_RD   = 2'd1;   // data holds the expected value
   localparam logic [1:0] OP_POLL = 2'd2;
   localparam int         POLL_LIMIT = 40;
   localparam int         BUSY_BIT   = 21;

   typedef struct packed {
      logic [1:0]                   kind;
      logic [`SBA_DMI_ADDR_W-1:0]   addr;
      logic [`SBA_DMI_DATA_W-1:0]   data;
   } step_t;

   logic                         clk, arst_n;
   logic                         dmi_en, dmi_wr;
   logic [`SBA_DMI_ADDR_W-1:0]   dmi_addr;
   logic [`SBA_DMI_DATA_W-1:0]   dmi_wdata, dmi_rdata;
   logic                         aw_valid, aw_ready, w_valid, w_ready, b_valid;
   logic                         ar_valid, ar_ready, r_valid;
   logic [`SBA_ADDR_W-1:0]       aw_addr, ar_addr;
   sb_bus_pkg::sb_size_t         aw_size, ar_size;
   logic [`SBA_BUS_DATA_W-1:0]   w_data, r_data;
   logic [`SBA_STRB_W-1:0]       w_strb;
   sb_bus_pkg::bus_resp_t        b_resp, r_resp;

   step_t                 steps[$];
   int                    errors;
   int                    checks;
   sb_bus_pkg::sb_size_t  exp_size;   // sbaccess as last written to sbcs

   sba_top u_dut (.*);

   sba_mem_model u_mem (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // size on the bus follows the sbaccess field
   always @(posedge clk) begin
      if (aw_valid) begin
         checks++;
         if (aw_size !== exp_size) begin
            $display("mismatch at %0t: aw_size %0d, expected %0d", $time, aw_size, exp_size);
            errors++;
         end
      end
      if (ar_valid) begin
         checks++;
         if (ar_size !== exp_size) begin
            $display("mismatch at %0t: ar_size %0d, expected %0d", $time, ar_size, exp_size);
            errors++;
         end
      end
   end

   // ************************************************************
   // DMI driver
   // ************************************************************
   task automatic dmi_access(input logic wr, input logic [`SBA_DMI_ADDR_W-1:0] addr,
                             input logic [`SBA_DMI_DATA_W-1:0] wdata,
                             output logic [`SBA_DMI_DATA_W-1:0] rdata);
      @(posedge clk);
      #10;
      dmi_en    = 1'b1;
      dmi_wr    = wr;
      dmi_addr  = addr;
      dmi_wdata = wdata;
      if (wr && addr == dm_reg_pkg::SBCS)
         exp_size = wdata[19:17];
      @(posedge clk);
      #10;
      dmi_en = 1'b0;
      dmi_wr = 1'b0;
      rdata  = dmi_rdata;   // registered, stable until the next strobe
   endtask

   task automatic check_read(input logic [`SBA_DMI_ADDR_W-1:0] addr,
                             input logic [`SBA_DMI_DATA_W-1:0] exp);
      logic [`SBA_DMI_DATA_W-1:0] got;
      dmi_access(1'b0, addr, '0, got);
      checks++;
      if (got !== exp) begin
         $display("mismatch at %0t: dmi addr 0x%h read 0x%h, expected 0x%h",
                  $time, addr, got, exp);
         errors++;
      end
   endtask

   task automatic wait_not_busy();
      logic [`SBA_DMI_DATA_W-1:0] sbcs;
      int polls;
      polls = 0;
      do begin
         dmi_access(1'b0, dm_reg_pkg::SBCS, '0, sbcs);
         polls++;
      end while (sbcs[BUSY_BIT] && polls < POLL_LIMIT);
      if (sbcs[BUSY_BIT]) begin
         $display("timeout at %0t: sbbusy still set after %0d polls", $time, polls);
         errors++;
      end
   endtask

   function automatic void add_step(input logic [1:0] kind,
                                    input logic [`SBA_DMI_ADDR_W-1:0] addr,
                                    input logic [`SBA_DMI_DATA_W-1:0] data);
      steps.push_back('{kind, addr, data});
   endfunction

   // ************************************************************
   // stimulus table
   // ************************************************************
   task automatic load_table();
      // 32-bit write, then read back through readonaddr
      add_step(OP_WR,   dm_reg_pkg::DMCONTROL,  32'h0000_0001);
      add_step(OP_RD,   dm_reg_pkg::DMCONTROL,  32'h0000_0001);
      add_step(OP_WR,   dm_reg_pkg::SBCS,       32'h0004_0000);
      add_step(OP_WR,   dm_reg_pkg::SBADDRESS0, 32'h0000_0040);
      add_step(OP_WR,   dm_reg_pkg::SBDATA0,    32'hcafe_f00d);
      add_step(OP_POLL, dm_reg_pkg::SBCS,       32'h0);
      add_step(OP_WR,   dm_reg_pkg::SBCS,       32'h0014_0000);
      add_step(OP_WR,   dm_reg_pkg::SBADDRESS0, 32'h0000_0040);
      add_step(OP_POLL, dm_reg_pkg::SBCS,       32'h0);
      add_step(OP_RD,   dm_reg_pkg::SBDATA0,    32'hcafe_f00d);
      add_step(OP_RD,   dm_reg_pkg::SBCS,       32'h2014_040f);
      // byte at 0x4d and half at 0x4a inside the word at 0x48
      add_step(OP_WR,   dm_reg_pkg::SBCS,       32'h0000_0000);
      add_step(OP_WR,   dm_reg_pkg::SBADDRESS0, 32'h0000_004d);
      add_step(OP_WR,   dm_reg_pkg::SBDATA0,    32'h0000_00a7);
      add_step(OP_POLL, dm_reg_pkg::SBCS,       32'h0);
      add_step(OP_WR,   dm_reg_pkg::SBCS,       32'h0002_0000);
      add_step(OP_WR,   dm_reg_pkg::SBADDRESS0, 32'h0000_004a);
      add_step(OP_WR,   dm_reg_pkg::SBDATA0,    32'h0000_beef);
      add_step(OP_POLL, dm_reg_pkg::SBCS,       32'h0);
      add_step(OP_WR,   dm_reg_pkg::SBCS,       32'h0016_0000);   // 64-bit read
      add_step(OP_WR,   dm_reg_pkg::SBADDRESS0, 32'h0000_0048);
      add_step(OP_POLL, dm_reg_pkg::SBCS,       32'h0);
      add_step(OP_RD,   dm_reg_pkg::SBDATA0,    32'hbeef_0048);
      add_step(OP_RD,   dm_reg_pkg::SBDATA1,    32'h5a00_a74c);
      add_step(OP_WR,   dm_reg_pkg::SBCS,       32'h0014_0000);
      add_step(OP_WR,   dm_reg_pkg::SBADDRESS0, 32'h0000_004c);
      add_step(OP_POLL, dm_reg_pkg::SBCS,       32'h0);
      add_step(OP_RD,   dm_reg_pkg::SBDATA0,    32'h5a00_a74c);
      add_step(OP_RD,   dm_reg_pkg::SBDATA1,    32'h0000_0000);
      // autoincrement with readondata walks 0x100, 0x104, 0x108
      add_step(OP_WR,   dm_reg_pkg::SBCS,       32'h0015_8000);
      add_step(OP_WR,   dm_reg_pkg::SBADDRESS0, 32'h0000_0100);
      add_step(OP_POLL, dm_reg_pkg::SBCS,       32'h0);
      add_step(OP_RD,   dm_reg_pkg::SBADDRESS0, 32'h0000_0104);
      add_step(OP_RD,   dm_reg_pkg::SBDATA0,    32'h5a00_0100);
      add_step(OP_POLL, dm_reg_pkg::SBCS,       32'h0);
      add_step(OP_RD,   dm_reg_pkg::SBDATA0,    32'h5a00_0104);
      add_step(OP_POLL, dm_reg_pkg::SBCS,       32'h0);
      add_step(OP_RD,   dm_reg_pkg::SBADDRESS0, 32'h0000_010c);
      add_step(OP_RD,   dm_reg_pkg::SBCS,       32'h2015_840f);
      // unaligned, bad size, bus error
      add_step(OP_WR,   dm_reg_pkg::SBCS,       32'h0004_0000);
      add_step(OP_WR,   dm_reg_pkg::SBADDRESS0, 32'h0000_0042);
      add_step(OP_WR,   dm_reg_pkg::SBDATA0,    32'h1111_1111);
      add_step(OP_POLL, dm_reg_pkg::SBCS,       32'h0);
      add_step(OP_RD,   dm_reg_pkg::SBCS,       32'h2004_340f);
      add_step(OP_WR,   dm_reg_pkg::SBCS,       32'h0004_7000);
      add_step(OP_RD,   dm_reg_pkg::SBCS,       32'h2004_040f);
      add_step(OP_WR,   dm_reg_pkg::SBCS,       32'h0014_0000);
      add_step(OP_WR,   dm_reg_pkg::SBADDRESS0, 32'h0000_0040);
      add_step(OP_POLL, dm_reg_pkg::SBCS,       32'h0);
      add_step(OP_RD,   dm_reg_pkg::SBDATA0,    32'hcafe_f00d);   // untouched by 0x42
      add_step(OP_WR,   dm_reg_pkg::SBCS,       32'h0008_0000);
      add_step(OP_WR,   dm_reg_pkg::SBDATA0,    32'h2222_2222);
      add_step(OP_POLL, dm_reg_pkg::SBCS,       32'h0);
      add_step(OP_RD,   dm_reg_pkg::SBCS,       32'h2008_440f);
      add_step(OP_WR,   dm_reg_pkg::SBCS,       32'h0000_7000);
      add_step(OP_RD,   dm_reg_pkg::SBCS,       32'h2000_040f);
      add_step(OP_WR,   dm_reg_pkg::SBCS,       32'h0014_0000);
      add_step(OP_WR,   dm_reg_pkg::SBADDRESS0, 32'h8000_0000);
      add_step(OP_POLL, dm_reg_pkg::SBCS,       32'h0);
      add_step(OP_RD,   dm_reg_pkg::SBCS,       32'h2014_240f);
      add_step(OP_WR,   dm_reg_pkg::SBCS,       32'h0004_7000);
      add_step(OP_RD,   dm_reg_pkg::SBCS,       32'h2004_040f);
      // sbdata1 written while the bus is busy
      add_step(OP_WR,   dm_reg_pkg::SBADDRESS0, 32'h0000_0050);
      add_step(OP_WR,   dm_reg_pkg::SBDATA0,    32'h3333_3333);
      add_step(OP_WR,   dm_reg_pkg::SBDATA1,    32'h4444_4444);
      add_step(OP_POLL, dm_reg_pkg::SBCS,       32'h0);
      add_step(OP_RD,   dm_reg_pkg::SBCS,       32'h2044_040f);
      add_step(OP_RD,   dm_reg_pkg::SBDATA1,    32'h0000_0000);
      add_step(OP_WR,   dm_reg_pkg::SBCS,       32'h0044_0000);
      add_step(OP_RD,   dm_reg_pkg::SBCS,       32'h2004_040f);
      // dmactive low leaves only the constant fields
      add_step(OP_WR,   dm_reg_pkg::DMCONTROL,  32'h0000_0000);
      add_step(OP_RD,   dm_reg_pkg::SBCS,       32'h2000_040f);
      add_step(OP_RD,   dm_reg_pkg::SBADDRESS0, 32'h0000_0000);
      add_step(OP_RD,   dm_reg_pkg::DMCONTROL,  32'h0000_0000);
   endtask

   initial begin
      int                          seed;
      logic [`SBA_DMI_DATA_W-1:0]  rd_unused;
      seed      = $urandom(32'h72ef_7e86);
      arst_n    = 1'b0;
      dmi_en    = 1'b0;
      dmi_wr    = 1'b0;
      dmi_addr  = '0;
      dmi_wdata = '0;
      exp_size  = '0;
      errors    = 0;
      checks    = 0;
      load_table();
      repeat (10) @(posedge clk);
      #10;
      arst_n = 1'b1;

      foreach (steps[i]) begin
         case (steps[i].kind)
            OP_WR:   dmi_access(1'b1, steps[i].addr, steps[i].data, rd_unused);
            OP_RD:   check_read(steps[i].addr, steps[i].data);
            default: wait_not_busy();
         endcase
      end

      checks++;
      if (aw_valid || w_valid || ar_valid) begin
         $display("bus valid is high at %0t while dmactive is low", $time);
         errors++;
      end

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

// ==== sba_top.f ====
+incdir+hdl
hdl/dm_reg_pkg.sv
hdl/sb_bus_pkg.sv
hdl/sba_dmi_regs.sv
hdl/sba_ctrl.sv
hdl/sba_lane_align.sv
hdl/sba_top.sv
dv/sba_mem_model.sv
dv/sba_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the system bus access testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module sba_tb -f sba_top.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vsba_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "No errors"; then
   exit 0
fi
exit 1
